// File: hdl/load_addr_stage.sv
`default_nettype none

module load_addr_stage
    import lsu_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      i_ld_vld,
    input  wire [LD_OP_W-1:0]        i_ld_op,
    input  wire [XLEN-1:0]           i_ld_src0,
    input  wire [XLEN-1:0]           i_ld_src1,
    input  wire [TAG_W-1:0]          i_ld_tag,
    input  wire [CRED_W-1:0]         i_credit_free,
    output logic                     o_ld_rdy,
    output logic                     o_s0_vld,
    output logic [ADDR_W-1:0]        o_s0_addr,
    output logic [XBYTES-1:0]        o_s0_byte_mask,
    output logic                     o_s0_signed,
    output logic [SIZE_CODE_W-1:0]   o_s0_size,
    output logic                     o_s0_misaligned,
    output logic [TAG_W-1:0]         o_s0_tag
);

    logic [LD_OP_W-1:0] s0_op;
    logic [XLEN-1:0]    s0_src0;
    logic [XLEN-1:0]    s0_src1;
    logic [XLEN-1:0]    s0_sum;
    logic [XBYTES-1:0]  size_mask;
    logic [OFF_W:0]     nbytes;
    logic [OFF_W:0]     end_byte;
    logic               accept;

    // the load sitting in s0 has not been charged a credit yet
    assign o_ld_rdy = i_credit_free > CRED_W'(o_s0_vld);
    assign accept   = i_ld_vld && o_ld_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_s0_vld <= 1'b0;
        end else begin
            o_s0_vld <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s0_op    <= i_ld_op;
            s0_src0  <= i_ld_src0;
            s0_src1  <= i_ld_src1;
            o_s0_tag <= i_ld_tag;
        end
    end

    // only the low address bits reach the RAM
    assign s0_sum    = s0_src0 + s0_src1;
    assign o_s0_addr = s0_sum[ADDR_W-1:0];

    always_comb begin
        case (s0_op)
            LD_LB:   {o_s0_size, o_s0_signed} = {SIZE_BYTE, 1'b1};
            LD_LH:   {o_s0_size, o_s0_signed} = {SIZE_HALF, 1'b1};
            LD_LW:   {o_s0_size, o_s0_signed} = {SIZE_WORD, 1'b1};
            LD_LBU:  {o_s0_size, o_s0_signed} = {SIZE_BYTE, 1'b0};
            LD_LHU:  {o_s0_size, o_s0_signed} = {SIZE_HALF, 1'b0};
            LD_LWU:  {o_s0_size, o_s0_signed} = {SIZE_WORD, 1'b0};
            // LD_LD and the unused code
            default: {o_s0_size, o_s0_signed} = {SIZE_DWORD, 1'b0};
        endcase
    end

    always_comb begin
        case (o_s0_size)
            SIZE_BYTE: size_mask = 8'h01;
            SIZE_HALF: size_mask = 8'h03;
            SIZE_WORD: size_mask = 8'h0f;
            default:   size_mask = 8'hff;
        endcase
    end

    // crossing the doubleword boundary
    assign nbytes          = (OFF_W+1)'(1) << o_s0_size;
    assign end_byte        = {1'b0, o_s0_addr[OFF_W-1:0]} + nbytes;
    assign o_s0_misaligned = end_byte > (OFF_W+1)'(XBYTES);

    // empty mask for a misaligned load, nothing is fetched for it
    assign o_s0_byte_mask = o_s0_misaligned ? '0 : size_mask << o_s0_addr[OFF_W-1:0];

endmodule

`default_nettype wire

// File: hdl/load_data_ram.sv
`default_nettype none

module load_data_ram
    import lsu_pkg::*;
(
    input  wire                  clk,
    input  wire                  i_rd_en,
    input  wire [DW_W-1:0]       i_rd_addr,
    input  wire                  i_wr_en,
    input  wire [DW_W-1:0]       i_wr_addr,
    input  wire [XLEN-1:0]       i_wr_data,
    input  wire [XBYTES-1:0]     i_wr_mask,
    output logic [XLEN-1:0]      o_rd_data
);

    logic [XLEN-1:0] mem [RAM_WORDS];

    // contents start at zero
    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // byte-masked write from the store drain
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            for (int b = 0; b < XBYTES; b++) begin
                if (i_wr_mask[b]) begin
                    mem[i_wr_addr][8*b +: 8] <= i_wr_data[8*b +: 8];
                end
            end
        end
    end

    // read-first, a same-edge write is not seen here
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/load_merge.sv
`default_nettype none

module load_merge
    import lsu_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      i_s1_vld,
    input  wire [OFF_W-1:0]          i_s1_offset,
    input  wire [SIZE_CODE_W-1:0]    i_s1_size,
    input  wire                      i_s1_signed,
    input  wire                      i_s1_misaligned,
    input  wire [ADDR_W-1:0]         i_s1_addr,
    input  wire [TAG_W-1:0]          i_s1_tag,
    input  wire [XLEN-1:0]           i_ram_data,
    input  wire [XLEN-1:0]           i_fwd_data,
    input  wire [XBYTES-1:0]         i_fwd_mask,
    input  wire                      i_wb_credit,
    output logic [CRED_W-1:0]        o_credit_free,
    output logic                     o_wb_vld,
    output logic [TAG_W-1:0]         o_wb_tag,
    output logic                     o_wb_except,
    output wb_word_t                 o_wb_word
);

    logic                    s1_vld;
    logic [OFF_W-1:0]        s1_offset;
    logic [SIZE_CODE_W-1:0]  s1_size;
    logic                    s1_signed;
    logic                    s1_misaligned;
    logic [ADDR_W-1:0]       s1_addr;
    logic [TAG_W-1:0]        s1_tag;
    logic [XLEN-1:0]         merged;
    logic [XLEN-1:0]         shifted;
    logic [XLEN-1:0]         extended;
    wb_word_t                wb_next;

    // s1 attributes, lined up with the RAM and lookup results
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
        end else begin
            s1_vld <= i_s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        s1_offset     <= i_s1_offset;
        s1_size       <= i_s1_size;
        s1_signed     <= i_s1_signed;
        s1_misaligned <= i_s1_misaligned;
        s1_addr       <= i_s1_addr;
        s1_tag        <= i_s1_tag;
    end

    // forwarded byte wins where the buffer had one
    always_comb begin
        for (int b = 0; b < XBYTES; b++) begin
            merged[8*b +: 8] = i_fwd_mask[b] ? i_fwd_data[8*b +: 8] : i_ram_data[8*b +: 8];
        end
    end

    assign shifted = merged >> {s1_offset, 3'b000};

    always_comb begin
        case (s1_size)
            SIZE_BYTE: extended = {{56{s1_signed & shifted[7]}}, shifted[7:0]};
            SIZE_HALF: extended = {{48{s1_signed & shifted[15]}}, shifted[15:0]};
            SIZE_WORD: extended = {{32{s1_signed & shifted[31]}}, shifted[31:0]};
            default:   extended = shifted;
        endcase
    end

    always_comb begin
        wb_next = '0;
        if (s1_misaligned) begin
            wb_next.exc.cause = CAUSE_LOAD_MISALIGNED;
            wb_next.exc.addr  = s1_addr;
        end else begin
            wb_next.data = extended;
        end
    end

    // writeback register
    always_ff @(posedge clk) begin
        if (rst) begin
            o_wb_vld <= 1'b0;
        end else begin
            o_wb_vld <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_vld) begin
            o_wb_tag    <= s1_tag;
            o_wb_except <= s1_misaligned;
            o_wb_word   <= wb_next;
        end
    end

    // a credit is charged as the load leaves s0
    always_ff @(posedge clk) begin
        if (rst) begin
            o_credit_free <= CRED_W'(WB_CREDITS);
        end else begin
            o_credit_free <= o_credit_free - CRED_W'(i_s1_vld) + CRED_W'(i_wb_credit);
        end
    end

endmodule

`default_nettype wire

// File: hdl/load_unit_top.sv
`default_nettype none

module load_unit_top
    import lsu_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    // load input
    input  wire                  i_ld_vld,
    input  wire [LD_OP_W-1:0]    i_ld_op,
    input  wire [XLEN-1:0]       i_ld_src0,
    input  wire [XLEN-1:0]       i_ld_src1,
    input  wire [TAG_W-1:0]      i_ld_tag,
    output logic                 o_ld_rdy,
    // store input
    input  wire                  i_st_vld,
    input  wire [ADDR_W-1:0]     i_st_addr,
    input  wire [ST_OP_W-1:0]    i_st_op,
    input  wire [XLEN-1:0]       i_st_data,
    output logic                 o_st_rdy,
    input  wire                  i_drain_en,
    // writeback
    input  wire                  i_wb_credit,
    output logic                 o_wb_vld,
    output logic [TAG_W-1:0]     o_wb_tag,
    output logic                 o_wb_except,
    output wb_word_t             o_wb_word
);

    logic [CRED_W-1:0]       credit_free;
    logic                    s0_vld;
    logic [ADDR_W-1:0]       s0_addr;
    logic [XBYTES-1:0]       s0_byte_mask;
    logic                    s0_signed;
    logic [SIZE_CODE_W-1:0]  s0_size;
    logic                    s0_misaligned;
    logic [TAG_W-1:0]        s0_tag;
    logic                    s0_access;
    logic                    drain_vld;
    logic [DW_W-1:0]         drain_addr;
    logic [XLEN-1:0]         drain_data;
    logic [XBYTES-1:0]       drain_mask;
    logic [XLEN-1:0]         ram_data;
    logic [XLEN-1:0]         fwd_data;
    logic [XBYTES-1:0]       fwd_mask;

    load_addr_stage u_addr (
        .clk             (clk),
        .rst             (rst),
        .i_ld_vld        (i_ld_vld),
        .i_ld_op         (i_ld_op),
        .i_ld_src0       (i_ld_src0),
        .i_ld_src1       (i_ld_src1),
        .i_ld_tag        (i_ld_tag),
        .i_credit_free   (credit_free),
        .o_ld_rdy        (o_ld_rdy),
        .o_s0_vld        (s0_vld),
        .o_s0_addr       (s0_addr),
        .o_s0_byte_mask  (s0_byte_mask),
        .o_s0_signed     (s0_signed),
        .o_s0_size       (s0_size),
        .o_s0_misaligned (s0_misaligned),
        .o_s0_tag        (s0_tag)
    );

    // misaligned loads carry an empty mask and skip both arrays
    assign s0_access = s0_vld && (|s0_byte_mask);

    load_data_ram u_ram (
        .clk       (clk),
        .i_rd_en   (s0_access),
        .i_rd_addr (s0_addr[ADDR_W-1:OFF_W]),
        .i_wr_en   (drain_vld),
        .i_wr_addr (drain_addr),
        .i_wr_data (drain_data),
        .i_wr_mask (drain_mask),
        .o_rd_data (ram_data)
    );

    store_buffer u_sb (
        .clk          (clk),
        .rst          (rst),
        .i_st_vld     (i_st_vld),
        .i_st_addr    (i_st_addr),
        .i_st_op      (i_st_op),
        .i_st_data    (i_st_data),
        .i_drain_en   (i_drain_en),
        .i_lk_vld     (s0_access),
        .i_lk_addr    (s0_addr[ADDR_W-1:OFF_W]),
        .o_st_rdy     (o_st_rdy),
        .o_drain_vld  (drain_vld),
        .o_drain_addr (drain_addr),
        .o_drain_data (drain_data),
        .o_drain_mask (drain_mask),
        .o_lk_data    (fwd_data),
        .o_lk_mask    (fwd_mask)
    );

    load_merge u_merge (
        .clk             (clk),
        .rst             (rst),
        .i_s1_vld        (s0_vld),
        .i_s1_offset     (s0_addr[OFF_W-1:0]),
        .i_s1_size       (s0_size),
        .i_s1_signed     (s0_signed),
        .i_s1_misaligned (s0_misaligned),
        .i_s1_addr       (s0_addr),
        .i_s1_tag        (s0_tag),
        .i_ram_data      (ram_data),
        .i_fwd_data      (fwd_data),
        .i_fwd_mask      (fwd_mask),
        .i_wb_credit     (i_wb_credit),
        .o_credit_free   (credit_free),
        .o_wb_vld        (o_wb_vld),
        .o_wb_tag        (o_wb_tag),
        .o_wb_except     (o_wb_except),
        .o_wb_word       (o_wb_word)
    );

endmodule

`default_nettype wire

// File: hdl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // datapath and address widths
    localparam int XLEN     = 64;
    localparam int XBYTES   = XLEN / 8;
    localparam int ADDR_W   = 12;
    localparam int OFF_W    = 3;
    localparam int DW_W     = ADDR_W - OFF_W;
    localparam int RAM_WORDS = 1 << DW_W;
    localparam int TAG_W    = 4;

    // store buffer sizing, depth must be a power of two
    localparam int SB_DEPTH = 4;
    localparam int SB_IDX_W = $clog2(SB_DEPTH);
    localparam int SB_CNT_W = $clog2(SB_DEPTH + 1);

    // writeback credits granted by the consumer after reset
    localparam int WB_CREDITS = 2;
    localparam int CRED_W     = $clog2(WB_CREDITS + 1);

    // load opcodes
    localparam int LD_OP_W = 3;
    localparam logic [LD_OP_W-1:0] LD_LB  = 3'd0;
    localparam logic [LD_OP_W-1:0] LD_LH  = 3'd1;
    localparam logic [LD_OP_W-1:0] LD_LW  = 3'd2;
    localparam logic [LD_OP_W-1:0] LD_LD  = 3'd3;
    localparam logic [LD_OP_W-1:0] LD_LBU = 3'd4;
    localparam logic [LD_OP_W-1:0] LD_LHU = 3'd5;
    localparam logic [LD_OP_W-1:0] LD_LWU = 3'd6;

    // store size codes
    localparam int ST_OP_W = 2;
    localparam logic [ST_OP_W-1:0] ST_SB = 2'd0;
    localparam logic [ST_OP_W-1:0] ST_SH = 2'd1;
    localparam logic [ST_OP_W-1:0] ST_SW = 2'd2;
    localparam logic [ST_OP_W-1:0] ST_SD = 2'd3;

    // access size as log2 of the byte count
    localparam int SIZE_CODE_W = 2;
    localparam logic [SIZE_CODE_W-1:0] SIZE_BYTE  = 2'd0;
    localparam logic [SIZE_CODE_W-1:0] SIZE_HALF  = 2'd1;
    localparam logic [SIZE_CODE_W-1:0] SIZE_WORD  = 2'd2;
    localparam logic [SIZE_CODE_W-1:0] SIZE_DWORD = 2'd3;

    localparam int CAUSE_W = 4;
    localparam logic [CAUSE_W-1:0] CAUSE_LOAD_MISALIGNED = 4'd4;

    typedef struct packed {
        logic [CAUSE_W-1:0]                cause;
        logic [ADDR_W-1:0]                 addr;
        logic [XLEN-CAUSE_W-ADDR_W-1:0]    pad;
    } exc_rec_t;

    // writeback word, view chosen by o_wb_except
    typedef union packed {
        logic [XLEN-1:0] data;
        exc_rec_t        exc;
    } wb_word_t;

endpackage

`default_nettype wire

// File: hdl/store_buffer.sv
`default_nettype none

module store_buffer
    import lsu_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  i_st_vld,
    input  wire [ADDR_W-1:0]     i_st_addr,
    input  wire [ST_OP_W-1:0]    i_st_op,
    input  wire [XLEN-1:0]       i_st_data,
    input  wire                  i_drain_en,
    input  wire                  i_lk_vld,
    input  wire [DW_W-1:0]       i_lk_addr,
    output logic                 o_st_rdy,
    output logic                 o_drain_vld,
    output logic [DW_W-1:0]      o_drain_addr,
    output logic [XLEN-1:0]      o_drain_data,
    output logic [XBYTES-1:0]    o_drain_mask,
    output logic [XLEN-1:0]      o_lk_data,
    output logic [XBYTES-1:0]    o_lk_mask
);

    // entries held already aligned to their doubleword
    logic [DW_W-1:0]     ent_addr [SB_DEPTH];
    logic [XLEN-1:0]     ent_data [SB_DEPTH];
    logic [XBYTES-1:0]   ent_mask [SB_DEPTH];

    logic [SB_IDX_W-1:0] head;
    logic [SB_IDX_W-1:0] tail;
    logic [SB_CNT_W-1:0] count;
    logic                push;
    logic                pop;
    logic [OFF_W-1:0]    st_off;
    logic [XBYTES-1:0]   st_size_mask;
    logic [XLEN-1:0]     lk_data_next;
    logic [XBYTES-1:0]   lk_mask_next;

    assign o_st_rdy    = count != SB_CNT_W'(SB_DEPTH);
    assign push        = i_st_vld && o_st_rdy;
    assign o_drain_vld = i_drain_en && (count != '0);
    assign pop         = o_drain_vld;
    assign st_off      = i_st_addr[OFF_W-1:0];

    always_comb begin
        case (i_st_op)
            ST_SB:   st_size_mask = 8'h01;
            ST_SH:   st_size_mask = 8'h03;
            ST_SW:   st_size_mask = 8'h0f;
            ST_SD:   st_size_mask = 8'hff;
            default: st_size_mask = 8'hff;
        endcase
    end

    // bytes past the doubleword end are dropped by the shift
    always_ff @(posedge clk) begin
        if (push) begin
            ent_addr[tail] <= i_st_addr[ADDR_W-1:OFF_W];
            ent_data[tail] <= i_st_data << {st_off, 3'b000};
            ent_mask[tail] <= st_size_mask << st_off;
        end
    end

    // pointers wrap naturally
    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            count <= count + SB_CNT_W'(push) - SB_CNT_W'(pop);
        end
    end

    // oldest entry goes to the RAM write port
    assign o_drain_addr = ent_addr[head];
    assign o_drain_data = ent_data[head];
    assign o_drain_mask = ent_mask[head];

    // walk oldest to youngest so younger bytes overwrite older ones
    always_comb begin
        logic [SB_IDX_W-1:0] idx;
        lk_data_next = '0;
        lk_mask_next = '0;
        for (int k = 0; k < SB_DEPTH; k++) begin
            idx = head + SB_IDX_W'(k);
            if ((SB_CNT_W'(k) < count) && (ent_addr[idx] == i_lk_addr)) begin
                for (int b = 0; b < XBYTES; b++) begin
                    if (ent_mask[idx][b]) begin
                        lk_data_next[8*b +: 8] = ent_data[idx][8*b +: 8];
                        lk_mask_next[b]        = 1'b1;
                    end
                end
            end
        end
    end

    // registered at the same edge as the RAM read
    always_ff @(posedge clk) begin
        if (i_lk_vld) begin
            o_lk_data <= lk_data_next;
            o_lk_mask <= lk_mask_next;
        end
    end

endmodule

`default_nettype wire

// File: load_unit_top.f
hdl/lsu_pkg.sv
hdl/load_addr_stage.sv
hdl/load_data_ram.sv
hdl/store_buffer.sv
hdl/load_merge.sv
hdl/load_unit_top.sv
tb/tb_clkgen.sv
tb/load_unit_tb.sv

// File: tb/load_unit_tb.sv
`default_nettype none

module load_unit_tb
    import lsu_pkg::*;
();

    typedef enum logic [2:0] {K_ST, K_LD, K_DRAIN, K_FULL, K_HOLD, K_LDBLK} kind_t;

    // one table row where val is src1 for loads and the data for stores
    typedef struct packed {
        kind_t             kind;
        logic [2:0]        op;
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   val;
        logic              drain;
        logic [XLEN-1:0]   exp;
    } op_entry_t;

    logic clk;
    logic rst;
    logic i_ld_vld;
    logic [LD_OP_W-1:0] i_ld_op;
    logic [XLEN-1:0] i_ld_src0;
    logic [XLEN-1:0] i_ld_src1;
    logic [TAG_W-1:0] i_ld_tag;
    logic o_ld_rdy;
    logic i_st_vld;
    logic [ADDR_W-1:0] i_st_addr;
    logic [ST_OP_W-1:0] i_st_op;
    logic [XLEN-1:0] i_st_data;
    logic o_st_rdy;
    logic i_drain_en;
    logic i_wb_credit;
    logic o_wb_vld;
    logic [TAG_W-1:0] o_wb_tag;
    logic o_wb_except;
    wb_word_t o_wb_word;

    // memory model and the pending stores in age order
    logic [7:0] mem_model [1 << ADDR_W];
    int pq_addr [$];
    int pq_len [$];
    logic [XLEN-1:0] pq_data [$];

    // expected results indexed by tag
    logic [XLEN-1:0] exp_word [1 << TAG_W];
    bit exp_exc [1 << TAG_W];
    bit exp_pend [1 << TAG_W];
    int exp_cyc [1 << TAG_W];

    op_entry_t table_q [$];
    logic [XLEN-1:0] cur_exp;
    logic [TAG_W-1:0] next_tag;
    integer seed;
    int cyc = 0;
    int wait_limit = 200;
    int pend_n;
    int got_n;
    int owed;
    int credit_gap;
    int hold_base;
    bit hold_credits;
    bit credit_now;

    tb_clkgen #(.PERIOD(20)) u_clkgen (.o_clk(clk));

    load_unit_top uut (
        .clk         (clk),
        .rst         (rst),
        .i_ld_vld    (i_ld_vld),
        .i_ld_op     (i_ld_op),
        .i_ld_src0   (i_ld_src0),
        .i_ld_src1   (i_ld_src1),
        .i_ld_tag    (i_ld_tag),
        .o_ld_rdy    (o_ld_rdy),
        .i_st_vld    (i_st_vld),
        .i_st_addr   (i_st_addr),
        .i_st_op     (i_st_op),
        .i_st_data   (i_st_data),
        .o_st_rdy    (o_st_rdy),
        .i_drain_en  (i_drain_en),
        .i_wb_credit (i_wb_credit),
        .o_wb_vld    (o_wb_vld),
        .o_wb_tag    (o_wb_tag),
        .o_wb_except (o_wb_except),
        .o_wb_word   (o_wb_word)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic stop_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic value_error(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic timeout_error(input string what);
        $display("timed out at time %0t waiting for %s", $time, what);
        stop_run();
    endtask

    task automatic add_op(input kind_t kind, input logic [2:0] op, input logic [ADDR_W-1:0] addr,
                          input logic [XLEN-1:0] val, input logic drain, input logic [XLEN-1:0] exp);
        table_q.push_back('{kind, op, addr, val, drain, exp});
    endtask

    // byte from the youngest pending store covering it or from memory
    function automatic logic [7:0] byte_at(input int a);
        logic [7:0] b;
        b = mem_model[a];
        foreach (pq_addr[i]) begin
            if (a >= pq_addr[i] && a < pq_addr[i] + pq_len[i]) begin
                b = 8'(pq_data[i] >> (8 * (a - pq_addr[i])));
            end
        end
        return b;
    endfunction

    task automatic record_load();
        int a;
        int n;
        int t;
        bit sgn;
        bit mis;
        logic [XLEN-1:0] v;
        a = int'(ADDR_W'(i_ld_src0 + i_ld_src1));
        t = int'(i_ld_tag);
        case (i_ld_op)
            LD_LB, LD_LBU: n = 1;
            LD_LH, LD_LHU: n = 2;
            LD_LW, LD_LWU: n = 4;
            default:       n = 8;
        endcase
        sgn = (i_ld_op == LD_LB) || (i_ld_op == LD_LH) || (i_ld_op == LD_LW);
        mis = (a % 8) + n > 8;
        v = '0;
        if (mis) begin
            // cause in the top nibble and faulting address below it
            v[63:60] = CAUSE_LOAD_MISALIGNED;
            v[59:48] = ADDR_W'(a);
        end else begin
            for (int k = 0; k < n; k++) begin
                v[8*k +: 8] = byte_at(a + k);
            end
            if (sgn && v[8*n-1]) begin
                for (int k = 8 * n; k < XLEN; k++) begin
                    v[k] = 1'b1;
                end
            end
        end
        assert (v == cur_exp)
            else value_error($sformatf("model gives %h for %h, table has %h", v, a, cur_exp));
        exp_word[t] = v;
        exp_exc[t]  = mis;
        exp_cyc[t]  = cyc;
        exp_pend[t] = 1'b1;
        pend_n++;
    endtask

    // one clock edge with the model updated as the DUT takes it
    task automatic tick();
        bit st_acc;
        bit ld_acc;
        bit drn;
        st_acc = i_st_vld && o_st_rdy;
        ld_acc = i_ld_vld && o_ld_rdy;
        drn    = i_drain_en && (pq_addr.size() > 0);
        @(posedge clk);
        #2;
        if (drn) begin
            for (int k = 0; k < pq_len[0]; k++) begin
                mem_model[pq_addr[0] + k] = 8'(pq_data[0] >> (8 * k));
            end
            void'(pq_addr.pop_front());
            void'(pq_len.pop_front());
            void'(pq_data.pop_front());
        end
        if (st_acc) begin
            pq_addr.push_back(int'(i_st_addr));
            pq_len.push_back(1 << i_st_op);
            pq_data.push_back(i_st_data);
        end
        if (ld_acc) begin
            record_load();
        end
    endtask

    task automatic issue_load(input op_entry_t e);
        int n;
        i_ld_vld  = 1'b1;
        i_ld_op   = e.op;
        i_ld_src1 = e.val;
        i_ld_src0 = XLEN'(e.addr) - e.val;
        i_ld_tag  = next_tag;
        cur_exp   = e.exp;
        if (e.kind == K_LDBLK) begin
            // admission stays closed with no credit left
            repeat (8) begin
                assert (!o_ld_rdy) else value_error("o_ld_rdy high with no credit left");
                tick();
            end
            assert (got_n - hold_base == WB_CREDITS)
                else value_error($sformatf("%0d results while credits held", got_n - hold_base));
            hold_credits = 1'b0;
        end
        for (n = 0; !o_ld_rdy; n++) begin
            assert (n < wait_limit) else timeout_error("o_ld_rdy");
            tick();
        end
        tick();
        i_ld_vld = 1'b0;
        next_tag = next_tag + 1'b1;
    endtask

    task automatic apply_entry(input op_entry_t e);
        int n;
        i_drain_en = e.drain;
        case (e.kind)
            K_ST: begin
                i_st_vld  = 1'b1;
                i_st_addr = e.addr;
                i_st_op   = e.op[ST_OP_W-1:0];
                i_st_data = e.val;
                for (n = 0; !o_st_rdy; n++) begin
                    assert (n < wait_limit) else timeout_error("o_st_rdy");
                    tick();
                end
                tick();
                i_st_vld = 1'b0;
            end
            K_LD, K_LDBLK: begin
                issue_load(e);
            end
            K_DRAIN: begin
                i_drain_en = 1'b1;
                for (n = 0; pq_addr.size() > 0; n++) begin
                    assert (n < wait_limit) else timeout_error("the store buffer to drain");
                    tick();
                end
            end
            K_FULL: begin
                assert (!o_st_rdy) else value_error("o_st_rdy high with four stores buffered");
                i_drain_en = 1'b1;
                tick();
                assert (o_st_rdy) else value_error("o_st_rdy still low after one drain");
            end
            default: begin
                // let every result and credit settle before holding credits
                for (n = 0; pend_n > 0 || owed > 0; n++) begin
                    assert (n < wait_limit) else timeout_error("outstanding results");
                    tick();
                end
                tick();
                tick();
                hold_credits = 1'b1;
                hold_base    = got_n;
            end
        endcase
        i_drain_en = 1'b0;
    endtask

    task automatic check_result();
        int t;
        t = int'(o_wb_tag);
        assert (exp_pend[t]) else value_error($sformatf("result with tag %0d not expected", t));
        assert (cyc == exp_cyc[t] + 2)
            else value_error($sformatf("tag %0d after %0d edges", t, cyc - exp_cyc[t] + 1));
        assert (o_wb_except == exp_exc[t])
            else value_error($sformatf("tag %0d except flag %b", t, o_wb_except));
        if (exp_exc[t]) begin
            assert (o_wb_word.exc.cause == CAUSE_LOAD_MISALIGNED)
                else value_error($sformatf("tag %0d cause %0d", t, o_wb_word.exc.cause));
        end
        assert (o_wb_word.data == exp_word[t])
            else value_error($sformatf("tag %0d got %h expected %h", t, o_wb_word.data,
                                       exp_word[t]));
        exp_pend[t] = 1'b0;
        pend_n--;
        got_n++;
        owed++;
    endtask

    // one credit per absorbed result, spaced by a random gap
    function automatic bit credit_due();
        bit give;
        give = 1'b0;
        if (credit_gap > 0) begin
            credit_gap--;
        end else if (!hold_credits && owed > 0) begin
            give = 1'b1;
            owed--;
            credit_gap = int'($unsigned($random(seed)) % 4);
        end
        return give;
    endfunction

    // consumer samples results and picks its credit at +1, drives the credit at +2
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (!rst && o_wb_vld) begin
                check_result();
            end
            credit_now = credit_due();
            #1;
            i_wb_credit = credit_now;
        end
    end

    initial begin
        seed         = 72786;
        rst          = 1'b1;
        i_ld_vld     = 1'b0;
        i_ld_op      = '0;
        i_ld_src0    = '0;
        i_ld_src1    = '0;
        i_ld_tag     = '0;
        i_st_vld     = 1'b0;
        i_st_addr    = '0;
        i_st_op      = '0;
        i_st_data    = '0;
        i_drain_en   = 1'b0;
        i_wb_credit  = 1'b0;
        next_tag     = '0;
        cur_exp      = '0;
        pend_n       = 0;
        got_n        = 0;
        owed         = 0;
        credit_gap   = 0;
        hold_base    = 0;
        hold_credits = 1'b0;
        credit_now   = 1'b0;
        for (int i = 0; i < (1 << ADDR_W); i++) begin
            mem_model[i] = 8'h00;
        end
        for (int i = 0; i < (1 << TAG_W); i++) begin
            exp_pend[i] = 1'b0;
        end

        // fill, full buffer, drain, then loads from RAM
        add_op(K_ST, 3'(ST_SD), 12'h100, 64'h8877_6655_4433_2211, 1'b0, '0);
        add_op(K_ST, 3'(ST_SW), 12'h108, 64'h0000_0000_f0e0_d0c0, 1'b0, '0);
        add_op(K_ST, 3'(ST_SH), 12'h10c, 64'h0000_0000_0000_8180, 1'b0, '0);
        add_op(K_ST, 3'(ST_SB), 12'h10f, 64'h0000_0000_0000_00fe, 1'b0, '0);
        add_op(K_FULL, 3'd0, 12'h000, 64'h0, 1'b0, '0);
        add_op(K_DRAIN, 3'd0, 12'h000, 64'h0, 1'b1, '0);
        add_op(K_LD, LD_LB, 12'h107, 64'h40, 1'b0, 64'hffff_ffff_ffff_ff88);
        add_op(K_LD, LD_LBU, 12'h107, 64'h0, 1'b0, 64'h0000_0000_0000_0088);
        add_op(K_LD, LD_LH, 12'h106, 64'hffff_ffff_ffff_ff00, 1'b0, 64'hffff_ffff_ffff_8877);
        add_op(K_LD, LD_LHU, 12'h102, 64'h123, 1'b0, 64'h0000_0000_0000_4433);
        add_op(K_LD, LD_LW, 12'h104, 64'h4, 1'b0, 64'hffff_ffff_8877_6655);
        add_op(K_LD, LD_LWU, 12'h108, 64'h1000, 1'b0, 64'h0000_0000_f0e0_d0c0);
        add_op(K_LD, LD_LW, 12'h100, 64'h0, 1'b0, 64'h0000_0000_4433_2211);
        add_op(K_LD, LD_LD, 12'h100, 64'h80, 1'b0, 64'h8877_6655_4433_2211);
        add_op(K_LD, LD_LD, 12'h108, 64'h8, 1'b0, 64'hfe00_8180_f0e0_d0c0);
        add_op(K_LD, LD_LH, 12'h10c, 64'h0, 1'b0, 64'hffff_ffff_ffff_8180);
        // forwarding with two stores to byte 0x203
        add_op(K_ST, 3'(ST_SD), 12'h200, 64'h0102_0304_0506_0708, 1'b0, '0);
        add_op(K_ST, 3'(ST_SB), 12'h203, 64'h0000_0000_0000_00aa, 1'b0, '0);
        add_op(K_ST, 3'(ST_SB), 12'h203, 64'h0000_0000_0000_00bb, 1'b0, '0);
        add_op(K_LD, LD_LD, 12'h200, 64'h10, 1'b0, 64'h0102_0304_bb06_0708);
        add_op(K_LD, LD_LB, 12'h203, 64'h0, 1'b0, 64'hffff_ffff_ffff_ffbb);
        add_op(K_LD, LD_LW, 12'h200, 64'h3, 1'b0, 64'hffff_ffff_bb06_0708);
        // partial overlap of buffer and RAM bytes
        add_op(K_ST, 3'(ST_SH), 12'h104, 64'h0000_0000_0000_a5b6, 1'b0, '0);
        add_op(K_LD, LD_LD, 12'h100, 64'h0, 1'b0, 64'h8877_a5b6_4433_2211);
        add_op(K_LD, LD_LW, 12'h104, 64'h20, 1'b0, 64'hffff_ffff_8877_a5b6);
        // drains landing on the accept and lookup edges
        add_op(K_LD, LD_LWU, 12'h104, 64'h0, 1'b1, 64'h0000_0000_8877_a5b6);
        add_op(K_LD, LD_LD, 12'h200, 64'h8, 1'b1, 64'h0102_0304_bb06_0708);
        add_op(K_LD, LD_LBU, 12'h203, 64'h0, 1'b1, 64'h0000_0000_0000_00bb);
        add_op(K_DRAIN, 3'd0, 12'h000, 64'h0, 1'b1, '0);
        add_op(K_LD, LD_LW, 12'h104, 64'h0, 1'b0, 64'hffff_ffff_8877_a5b6);
        // misaligned
        add_op(K_LD, LD_LH, 12'h107, 64'h7, 1'b0, 64'h4107_0000_0000_0000);
        add_op(K_LD, LD_LW, 12'h105, 64'h0, 1'b0, 64'h4105_0000_0000_0000);
        add_op(K_LD, LD_LD, 12'h101, 64'h100, 1'b0, 64'h4101_0000_0000_0000);
        // credits withheld
        add_op(K_HOLD, 3'd0, 12'h000, 64'h0, 1'b0, '0);
        add_op(K_LD, LD_LD, 12'h100, 64'h0, 1'b0, 64'h8877_a5b6_4433_2211);
        add_op(K_LD, LD_LBU, 12'h10f, 64'h0, 1'b0, 64'h0000_0000_0000_00fe);
        add_op(K_LDBLK, LD_LHU, 12'h10c, 64'h0, 1'b0, 64'h0000_0000_0000_8180);
        add_op(K_LD, LD_LD, 12'h108, 64'h0, 1'b0, 64'hfe00_8180_f0e0_d0c0);

        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        assert (o_ld_rdy && o_st_rdy && !o_wb_vld)
            else value_error("handshake outputs wrong after reset");

        foreach (table_q[i]) begin
            apply_entry(table_q[i]);
        end
        for (int n = 0; pend_n > 0; n++) begin
            assert (n < wait_limit) else timeout_error("the last results");
            tick();
        end
        // any late extra result fails in the consumer
        repeat (6) tick();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD = 20
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD / 2) o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire
